//--- src/ctrlPkg.sv
/* Shared encodings for the RV32IM pipeline controller
   Only base integer and M opcodes are decoded. Any other opcode is illegal */
`default_nettype none

package ctrlPkg;

  //////////////////////////////
  // Field types
  typedef logic [31:0] instrT;     // Raw instruction word
  typedef logic [4:0]  regAddrT;   // Register file index
  typedef logic [2:0]  funct3T;
  typedef logic [2:0]  aluSelT;    // funct3 for ALU ops, add otherwise
  typedef logic [1:0]  memRwT;     // {read, write}

  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opImm    = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,  // R-type and M-type share this
    opLui    = 7'b0110111,
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111
  } opcodeT;

  typedef enum logic [2:0] {immI = 3'd0, immS = 3'd1, immB = 3'd2, immJ = 3'd3, immU = 3'd4} immSrcT;
  typedef enum logic [2:0] {resAlu = 3'd0, resMem = 3'd1, resPc4 = 3'd2, resMdu = 3'd3} resultSrcT;
  typedef enum logic [1:0] {fwdNone = 2'd0, fwdW = 2'd1, fwdM = 2'd2} fwdSelT;

  //////////////////////////////
  // Instruction field positions
  localparam int opcodeLsb = 0;
  localparam int opcodeMsb = 6;
  localparam int rdLsb     = 7;
  localparam int rdMsb     = 11;
  localparam int funct3Lsb = 12;
  localparam int funct3Msb = 14;
  localparam int rs1Lsb    = 15;
  localparam int rs1Msb    = 19;
  localparam int rs2Lsb    = 20;
  localparam int rs2Msb    = 24;
  localparam int funct7Lsb = 25;
  localparam int funct7Msb = 31;

  // funct7 patterns
  localparam logic [6:0] funct7Zero = 7'b0000000;  // Plain R-type, logical shifts
  localparam logic [6:0] funct7Alt  = 7'b0100000;  // sub, sra, srai
  localparam logic [6:0] funct7Mul  = 7'b0000001;  // mul/div group

  localparam regAddrT regZero = 5'd0;  // x0, never written
  localparam int memReadBit  = 1;      // Position inside memRwT
  localparam int memWriteBit = 0;
  localparam int ctrlWordW   = 16;     // Packed decode table row

endpackage

`default_nettype wire

//--- src/ctrlIf.sv
/* Bundles between decoder, stage registers and hazard unit
   clk only feeds the clocked checks inside the combinational blocks */
`default_nettype none

interface ctrlIf (input logic clk);
  import ctrlPkg::*;

  logic      regWrite;   // Writes rd
  resultSrcT resultSrc;  // Writeback source
  memRwT     memRw;      // Data memory access
  logic      jump, branch;
  logic      aluSrcA;    // 1 selects PC
  logic      aluSrcB;    // 1 selects immediate
  aluSelT    aluSelect;
  logic      subArith;   // Inverted operand or arithmetic shift
  logic      mdu;        // Multiply/divide unit
  funct3T    funct3;     // Kept for branch compare in E

  modport decoder (input clk, output regWrite, resultSrc, memRw, jump, branch, aluSrcA,
                   aluSrcB, aluSelect, subArith, mdu, funct3);
  modport stage   (input regWrite, resultSrc, memRw, jump, branch, aluSrcA, aluSrcB,
                   aluSelect, subArith, mdu, funct3);
  modport hazard  (input memRw);
endinterface

interface hazardIf (input logic clk);
  import ctrlPkg::*;

  regAddrT rs1E, rs2E, rdE, rdM, rdW;  // Pipelined register indices
  logic    regWriteM, regWriteW;
  memRwT   memRwE;
  logic    mduE;

  modport stage  (output rs1E, rs2E, rdE, rdM, rdW, regWriteM, regWriteW, memRwE, mduE);
  modport hazard (input clk, rs1E, rs2E, rdE, rdM, rdW, regWriteM, regWriteW, memRwE, mduE);
endinterface

`default_nettype wire

//--- src/instrDecoder.sv
/* Decode stage control for RV32IM, fully combinational
   Legality is checked exactly on funct3/funct7; an illegal word yields an all-zero bundle */
`default_nettype none

module instrDecoder (
  input  ctrlPkg::instrT   instrD,
  output ctrlPkg::immSrcT  immSrcD,
  output logic             illegalInstrD,
  output ctrlPkg::regAddrT rs1D,
  output ctrlPkg::regAddrT rs2D,
  output ctrlPkg::regAddrT rdD,
  ctrlIf.decoder           ctrl
);
  import ctrlPkg::*;

  opcodeT                 opD;
  funct3T                 funct3D;
  logic [6:0]             funct7D;
  logic                   f7Zero, f7Alt, f7Mul;
  logic                   loadOk, storeOk, immAluOk, regAluOk, branchOk, jalrOk;
  logic [ctrlWordW-1:0]   controlsD;                 // Table row
  logic [2:0]             immSrcBits, resultBits;
  logic                   aluOpD;                    // ALU op uses funct3
  logic                   subD, sraD, sltD, sltuD;

  //////////////////////////////
  // Field extraction
  assign opD     = opcodeT'(instrD[opcodeMsb:opcodeLsb]);
  assign funct3D = instrD[funct3Msb:funct3Lsb];
  assign funct7D = instrD[funct7Msb:funct7Lsb];
  assign rs1D    = instrD[rs1Msb:rs1Lsb];
  assign rs2D    = instrD[rs2Msb:rs2Lsb];
  assign rdD     = instrD[rdMsb:rdLsb];

  //////////////////////////////
  // Exact legality per opcode
  assign f7Zero   = (funct7D == funct7Zero);
  assign f7Alt    = (funct7D == funct7Alt);
  assign f7Mul    = (funct7D == funct7Mul);
  assign loadOk   = (funct3D != 3'b011) & (funct3D[2:1] != 2'b11);  // lb lh lw lbu lhu
  assign storeOk  = ~funct3D[2] & (funct3D != 3'b011);              // sb sh sw
  assign immAluOk = (funct3D == 3'b001) ? f7Zero :                  // slli
                    (funct3D == 3'b101) ? (f7Zero | f7Alt) : 1'b1;  // srli, srai
  assign regAluOk = f7Zero | (f7Alt & ((funct3D == 3'b000) | (funct3D == 3'b101)));
  assign branchOk = (funct3D[2:1] != 2'b01);                        // 010, 011 unused
  assign jalrOk   = (funct3D == 3'b000);

  // Main table
  // regWrite_immSrc_aluSrcA_aluSrcB_memRw_resultSrc_branch_aluOp_jump_mdu_illegal
  always_comb begin
    controlsD = 16'b0_000_0_0_00_000_0_0_0_0_1;  // Illegal
    case (opD)
      opLoad:   if (loadOk)   controlsD = 16'b1_000_0_1_10_001_0_0_0_0_0;
      opStore:  if (storeOk)  controlsD = 16'b0_001_0_1_01_000_0_0_0_0_0;
      opImm:    if (immAluOk) controlsD = 16'b1_000_0_1_00_000_0_1_0_0_0;
      opReg: begin
        if (regAluOk)
          controlsD = 16'b1_000_0_0_00_000_0_1_0_0_0;  // R-ALU
        else if (f7Mul)
          controlsD = 16'b1_000_0_0_00_011_0_0_0_1_0;  // mul/div, any funct3
      end
      opBranch: if (branchOk) controlsD = 16'b0_010_1_1_00_000_1_0_0_0_0;
      opJal:                  controlsD = 16'b1_011_1_1_00_010_0_0_1_0_0;
      opJalr:   if (jalrOk)   controlsD = 16'b1_000_0_1_00_010_0_0_1_0_0;
      opLui:                  controlsD = 16'b1_100_0_1_00_000_0_0_0_0_0;
      opAuipc:                controlsD = 16'b1_100_1_1_00_000_0_0_0_0_0;
      default:                controlsD = 16'b0_000_0_0_00_000_0_0_0_0_1;
    endcase
  end

  assign {ctrl.regWrite, immSrcBits, ctrl.aluSrcA, ctrl.aluSrcB, ctrl.memRw, resultBits,
          ctrl.branch, aluOpD, ctrl.jump, ctrl.mdu, illegalInstrD} = controlsD;
  assign immSrcD        = immSrcT'(immSrcBits);
  assign ctrl.resultSrc = resultSrcT'(resultBits);
  assign ctrl.funct3    = funct3D;

  //////////////////////////////
  // ALU select
  assign sltD  = (funct3D == 3'b010);
  assign sltuD = (funct3D == 3'b011);
  assign subD  = (funct3D == 3'b000) & funct7D[5] & (opD == opReg);  // addi has imm bits here
  assign sraD  = (funct3D == 3'b101) & funct7D[5];                   // sra and srai
  assign ctrl.aluSelect = aluOpD ? funct3D : 3'b000;                 // Address calc adds
  assign ctrl.subArith  = aluOpD & (subD | sraD | sltD | sltuD);

  // Nothing leaves Decode with side effects for an illegal word
  illegalIsQuiet: assert property (@(posedge ctrl.clk)
    illegalInstrD |-> !ctrl.regWrite && (ctrl.memRw == 2'b00));

endmodule

`default_nettype wire

//--- src/stagePipe.sv
/* E, M and W control registers plus branch resolution
   Flush beats stall in every stage; stall and flush are levels from the core hazard logic */
`default_nettype none

module stagePipe (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stallE, flushE,
  input  logic                stallM, flushM,
  input  logic                stallW, flushW,
  input  ctrlPkg::regAddrT    rs1D, rs2D, rdD,
  input  logic [1:0]          flagsE,         // {eq, lt}
  ctrlIf.stage                ctrl,
  hazardIf.stage              hz,
  output logic                pcSrcE,
  output logic                aluSrcAE, aluSrcBE,
  output ctrlPkg::aluSelT     aluSelectE,
  output logic                subArithE,
  output ctrlPkg::memRwT      memRwM,
  output logic                regWriteW,
  output ctrlPkg::resultSrcT  resultSrcW,
  output ctrlPkg::regAddrT    rdW
);
  import ctrlPkg::*;

  logic      regWriteE, jumpE, branchE, mduE;
  resultSrcT resultSrcE;
  memRwT     memRwE;
  funct3T    funct3E;
  regAddrT   rs1E, rs2E, rdE;
  logic      regWriteM;
  resultSrcT resultSrcM;
  regAddrT   rdM;
  logic      eqE, ltE, flagE;

  //////////////////////////////
  // Execute register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {regWriteE, jumpE, branchE, mduE, aluSrcAE, aluSrcBE, subArithE, memRwE} <= '0;
      {aluSelectE, funct3E, rs1E, rs2E, rdE} <= '0;
      resultSrcE <= resAlu;
    end else if (flushE) begin  // Bubble, even when stalled
      {regWriteE, jumpE, branchE, mduE, aluSrcAE, aluSrcBE, subArithE, memRwE} <= '0;
      {aluSelectE, funct3E, rs1E, rs2E, rdE} <= '0;
      resultSrcE <= resAlu;
    end else if (!stallE) begin
      {regWriteE, jumpE, branchE, mduE} <= {ctrl.regWrite, ctrl.jump, ctrl.branch, ctrl.mdu};
      {aluSrcAE, aluSrcBE, subArithE}   <= {ctrl.aluSrcA, ctrl.aluSrcB, ctrl.subArith};
      memRwE     <= ctrl.memRw;
      aluSelectE <= ctrl.aluSelect;
      funct3E    <= ctrl.funct3;
      resultSrcE <= ctrl.resultSrc;
      {rs1E, rs2E, rdE} <= {rs1D, rs2D, rdD};
    end
  end

  // Branch decision, eq or lt picked by funct3[2], funct3[0] inverts
  assign {eqE, ltE} = flagsE;
  assign flagE  = funct3E[2] ? ltE : eqE;
  assign pcSrcE = jumpE | (branchE & (flagE ^ funct3E[0]));

  //////////////////////////////
  // Memory register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {regWriteM, memRwM, rdM} <= '0;
      resultSrcM <= resAlu;
    end else if (flushM) begin
      {regWriteM, memRwM, rdM} <= '0;
      resultSrcM <= resAlu;
    end else if (!stallM) begin
      {regWriteM, memRwM, rdM} <= {regWriteE, memRwE, rdE};
      resultSrcM <= resultSrcE;
    end
  end

  //////////////////////////////
  // Writeback register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {regWriteW, rdW} <= '0;
      resultSrcW <= resAlu;
    end else if (flushW) begin
      {regWriteW, rdW} <= '0;
      resultSrcW <= resAlu;
    end else if (!stallW) begin
      {regWriteW, rdW} <= {regWriteM, rdM};
      resultSrcW <= resultSrcM;
    end
  end

  // Hazard view of the pipe
  assign {hz.rs1E, hz.rs2E, hz.rdE} = {rs1E, rs2E, rdE};
  assign {hz.rdM, hz.rdW}           = {rdM, rdW};
  assign hz.regWriteM = regWriteM;
  assign hz.regWriteW = regWriteW;
  assign hz.memRwE    = memRwE;
  assign hz.mduE      = mduE;

  // A stalled stage that is also flushed must come out empty
  flushWinsE: assert property (@(posedge clk) disable iff (!rstN)
    flushE && stallE |=> !regWriteE && !jumpE && !branchE && (memRwE == 2'b00));
  flushWinsM: assert property (@(posedge clk) disable iff (!rstN)
    flushM && stallM |=> !regWriteM && (memRwM == 2'b00));

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
/* Forwarding selects and Decode stall requests, combinational
   The surrounding core turns structuralStallD into stallD and flushE */
`default_nettype none

module hazardUnit (
  input  ctrlPkg::regAddrT rs1D, rs2D,
  ctrlIf.hazard            ctrl,
  hazardIf.hazard          hz,
  output ctrlPkg::fwdSelT  forwardAE, forwardBE,
  output logic             structuralStallD
);
  import ctrlPkg::*;

  logic matchDE;                                // Decode reads what E produces
  logic loadStallD, mduStallD, storeStallD;

  // M wins over W since it holds the younger result
  function automatic fwdSelT pickFwd(regAddrT rsE, regAddrT rdM, logic wrM,
                                     regAddrT rdW, logic wrW);
    fwdSelT sel;
    sel = fwdNone;
    if (rsE != regZero) begin
      if (wrM && (rsE == rdM))
        sel = fwdM;
      else if (wrW && (rsE == rdW))
        sel = fwdW;
    end
    return sel;
  endfunction

  //////////////////////////////
  // Forwarding
  assign forwardAE = pickFwd(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
  assign forwardBE = pickFwd(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);

  //////////////////////////////
  // Structural stalls
  assign matchDE     = ((rs1D == hz.rdE) | (rs2D == hz.rdE)) & (hz.rdE != regZero);
  assign loadStallD  = hz.memRwE[memReadBit] & matchDE;              // Load data too late
  assign mduStallD   = hz.mduE & matchDE;                            // Multicycle result
  assign storeStallD = ctrl.memRw[memReadBit] & hz.memRwE[memWriteBit]; // Store then load
  assign structuralStallD = loadStallD | mduStallD | storeStallD;

  // x0 reads stay on the register file path
  noFwdFromX0: assert property (@(posedge hz.clk)
    ((hz.rs1E == regZero) |-> (forwardAE == fwdNone)) and
    ((hz.rs2E == regZero) |-> (forwardBE == fwdNone)));

endmodule

`default_nettype wire

//--- src/controller.sv
/* Pipeline controller top for a five-stage RV32IM core
   stallD and flushD belong to the Decode instruction register, which lives in the datapath */
`default_nettype none

module controller (
  input  logic                clk,
  input  logic                rstN,
  // Decode
  input  ctrlPkg::instrT      instrD,
  input  logic                stallD, flushD,
  output ctrlPkg::immSrcT     immSrcD,
  output logic                illegalInstrD,
  output ctrlPkg::regAddrT    rs1D, rs2D,
  output logic                structuralStallD,
  // Execute
  input  logic                stallE, flushE,
  input  logic [1:0]          flagsE,           // {eq, lt}
  output logic                pcSrcE,
  output logic                aluSrcAE, aluSrcBE,
  output ctrlPkg::aluSelT     aluSelectE,
  output logic                subArithE,
  output ctrlPkg::fwdSelT     forwardAE, forwardBE,
  // Memory
  input  logic                stallM, flushM,
  output ctrlPkg::memRwT      memRwM,
  // Writeback
  input  logic                stallW, flushW,
  output logic                regWriteW,
  output ctrlPkg::resultSrcT  resultSrcW,
  output ctrlPkg::regAddrT    rdW
);
  import ctrlPkg::*;

  regAddrT rdD;  // Destination heading into E

  ctrlIf   ctrlBus (.clk(clk));  // Decode controls
  hazardIf hazBus  (.clk(clk));  // Pipe state for hazards

  instrDecoder decodeU (
    .instrD, .immSrcD, .illegalInstrD, .rs1D, .rs2D, .rdD,
    .ctrl(ctrlBus.decoder)
  );

  stagePipe pipeU (
    .clk, .rstN, .stallE, .flushE, .stallM, .flushM, .stallW, .flushW,
    .rs1D, .rs2D, .rdD, .flagsE,
    .ctrl(ctrlBus.stage), .hz(hazBus.stage),
    .pcSrcE, .aluSrcAE, .aluSrcBE, .aluSelectE, .subArithE,
    .memRwM, .regWriteW, .resultSrcW, .rdW
  );

  hazardUnit hazardU (
    .rs1D, .rs2D,
    .ctrl(ctrlBus.hazard), .hz(hazBus.hazard),
    .forwardAE, .forwardBE, .structuralStallD
  );

endmodule

`default_nettype wire

//--- sim/tbController.sv
/* Directed testbench for the pipeline controller
   Inputs change on rising edges, outputs are checked on falling edges
   A watchdog ends the run if any sequence stalls */
`default_nettype none

module tbController;
  import ctrlPkg::*;

  logic clk = 1'b0;
  logic rstN;
  instrT instrD;
  logic stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  logic [1:0] flagsE;  // {eq, lt}
  immSrcT immSrcD;
  logic illegalInstrD, structuralStallD, pcSrcE, aluSrcAE, aluSrcBE, subArithE;
  regAddrT rs1D, rs2D, rdW;
  aluSelT aluSelectE;
  fwdSelT forwardAE, forwardBE;
  memRwT memRwM;
  logic regWriteW;
  resultSrcT resultSrcW;

  integer seed = 32'h561a_e812;
  int errors = 0;
  int testErrors;
  int tests = 0;
  string curTest;
  localparam instrT nop = 32'h0000_0013;  // addi x0, x0, 0

  controller uut (.*);

  always #4 clk = ~clk;

  //////////////////////////////
  // Instruction builders
  function automatic instrT encR(logic [6:0] f7, regAddrT rs2, regAddrT rs1, logic [2:0] f3,
                                 regAddrT rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic instrT encI(logic [11:0] imm, regAddrT rs1, logic [2:0] f3, regAddrT rd,
                                 logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // Expected redirect per branch mnemonic
  function automatic logic expTaken(logic [2:0] f3, logic [1:0] fl, logic isJump);
    logic eq, lt, taken;
    eq = fl[1];
    lt = fl[0];
    case (f3)
      3'b000:         taken = eq;   // beq
      3'b001:         taken = !eq;  // bne
      3'b100, 3'b110: taken = lt;   // blt, bltu
      default:        taken = !lt;  // bge, bgeu
    endcase
    return isJump || taken;
  endfunction

  task automatic pickRegs(output regAddrT a, output regAddrT b);
    integer r;
    r = $random(seed);
    a = 5'd1 + 5'((r & 32'h7fff_ffff) % 15);  // 1..15
    b = a + 5'd16;                             // 17..31, never equal to a
  endtask

  //////////////////////////////
  // Typed compare tasks
  task automatic report(string what, int exp, int act);
    $display("mismatch %s %s: expected %0d, actual %0d", curTest, what, exp, act);
    errors++;
    testErrors++;
  endtask

  task automatic checkBit(string what, logic exp, logic act);
    if (act !== exp) report(what, exp, act);
  endtask

  task automatic checkImm(string what, immSrcT exp, immSrcT act);
    if (act !== exp) report(what, exp, act);
  endtask

  task automatic checkSel(string what, aluSelT exp, aluSelT act);
    if (act !== exp) report(what, exp, act);
  endtask

  task automatic checkRes(string what, resultSrcT exp, resultSrcT act);
    if (act !== exp) report(what, exp, act);
  endtask

  task automatic checkFwd(string what, fwdSelT exp, fwdSelT act);
    if (act !== exp) report(what, exp, act);
  endtask

  task automatic checkReg(string what, regAddrT exp, regAddrT act);
    if (act !== exp) report(what, exp, act);
  endtask

  task automatic checkMem(string what, memRwT exp, memRwT act);
    if (act !== exp) report(what, exp, act);
  endtask

  //////////////////////////////
  // Sequencing helpers
  task automatic waitCycles(int n);
    for (int i = 0; i < n; i++) @(posedge clk);  // Bounded by n
  endtask

  task automatic applyReset();
    @(posedge clk);
    rstN <= 1'b0;
    waitCycles(2);
    rstN <= 1'b1;
  endtask

  task automatic startTest(string name);
    curTest = name;
    testErrors = 0;
    tests++;
  endtask

  task automatic endTest();
    $display("test %-12s %s (%0d errors)", curTest, (testErrors == 0) ? "passed" : "FAILED",
             testErrors);
  endtask

  task automatic checkE(logic a, logic b, aluSelT sel, logic sub);
    checkBit("aluSrcAE", a, aluSrcAE);
    checkBit("aluSrcBE", b, aluSrcBE);
    checkSel("aluSelectE", sel, aluSelectE);
    checkBit("subArithE", sub, subArithE);
  endtask

  // Decode outputs in the same cycle, E outputs one edge later
  task automatic decodeCase(instrT ins, immSrcT imm, logic ill, logic a, logic b,
                            aluSelT sel, logic sub);
    @(posedge clk);
    instrD <= ins;
    @(negedge clk);
    checkImm("immSrcD", imm, immSrcD);
    checkBit("illegalInstrD", ill, illegalInstrD);
    @(posedge clk);
    instrD <= nop;
    @(negedge clk);
    checkE(a, b, sel, sub);
  endtask

  // Source indices leave Decode in the same cycle
  task automatic fieldCase(instrT ins, regAddrT rs1, regAddrT rs2);
    @(posedge clk);
    instrD <= ins;
    @(negedge clk);
    checkReg("rs1D", rs1, rs1D);
    checkReg("rs2D", rs2, rs2D);
    @(posedge clk);
    instrD <= nop;
  endtask

  // M stage after two edges, W stage after three
  task automatic wbCase(instrT ins, resultSrcT res, memRwT mem, regAddrT rd);
    @(posedge clk);
    instrD <= ins;
    @(posedge clk);
    instrD <= nop;
    @(posedge clk);
    @(negedge clk);
    checkMem("memRwM", mem, memRwM);
    @(posedge clk);
    @(negedge clk);
    checkBit("regWriteW", 1'b1, regWriteW);
    checkRes("resultSrcW", res, resultSrcW);
    checkReg("rdW", rd, rdW);
  endtask

  task automatic fwdCase(instrT prod, int gap, instrT cons, fwdSelT expA, fwdSelT expB);
    @(posedge clk);
    instrD <= prod;
    for (int i = 1; i < gap; i++) begin
      @(posedge clk);
      instrD <= nop;
    end
    @(posedge clk);
    instrD <= cons;
    @(posedge clk);
    instrD <= nop;
    @(negedge clk);
    checkFwd("forwardAE", expA, forwardAE);
    checkFwd("forwardBE", expB, forwardBE);
  endtask

  task automatic stallCase(string what, instrT first, instrT second, logic exp);
    @(posedge clk);
    instrD <= first;
    @(posedge clk);
    instrD <= second;  // first now in E
    @(negedge clk);
    checkBit(what, exp, structuralStallD);
    @(posedge clk);
    instrD <= nop;
  endtask

  //////////////////////////////
  // Tests
  task automatic testDecodeTable();
    regAddrT a, b;
    startTest("decode");
    decodeCase(encI(12'h004, 5'd2, 3'b010, 5'd5, opLoad), immI,
               1'b0, 1'b0, 1'b1, 3'd0, 1'b0);                                     // lw
    decodeCase(encR(7'h00, 5'd6, 5'd2, 3'b010, 5'd8, opStore), immS, 1'b0, 1'b0, 1'b1,
               3'd0, 1'b0);                                                        // sw
    decodeCase(encI(12'h011, 5'd1, 3'b000, 5'd3, opImm), immI, 1'b0, 1'b0, 1'b1, 3'd0, 1'b0);
    decodeCase(encI(12'h011, 5'd1, 3'b010, 5'd3, opImm), immI, 1'b0, 1'b0, 1'b1, 3'd2, 1'b1);
    decodeCase(encR(funct7Alt, 5'd4, 5'd1, 3'b000, 5'd3, opReg), immI, 1'b0, 1'b0, 1'b0,
               3'd0, 1'b1);                                                        // sub
    decodeCase(encR(funct7Alt, 5'd4, 5'd1, 3'b101, 5'd3, opReg), immI, 1'b0, 1'b0, 1'b0,
               3'd5, 1'b1);                                                        // sra
    decodeCase(encR(funct7Mul, 5'd4, 5'd1, 3'b100, 5'd3, opReg), immI, 1'b0, 1'b0, 1'b0,
               3'd0, 1'b0);                                                        // div
    decodeCase(encR(7'h00, 5'd4, 5'd1, 3'b001, 5'd0, opBranch), immB, 1'b0, 1'b1, 1'b1,
               3'd0, 1'b0);                                                        // bne
    decodeCase({20'h00010, 5'd1, opJal}, immJ, 1'b0, 1'b1, 1'b1, 3'd0, 1'b0);
    decodeCase(encI(12'h008, 5'd1, 3'b000, 5'd1, opJalr), immI, 1'b0, 1'b0, 1'b1, 3'd0, 1'b0);
    decodeCase({20'h12345, 5'd7, opLui}, immU, 1'b0, 1'b0, 1'b1, 3'd0, 1'b0);
    decodeCase({20'h12345, 5'd7, opAuipc}, immU, 1'b0, 1'b1, 1'b1, 3'd0, 1'b0);
    decodeCase(32'hffff_ffff, immI, 1'b1, 1'b0, 1'b0, 3'd0, 1'b0);               // Bad opcode
    pickRegs(a, b);
    fieldCase(encR(funct7Zero, a, b, 3'b000, 5'd3, opReg), b, a);                 // add x3
    endTest();
  endtask

  task automatic testWriteback();
    regAddrT a, b;
    startTest("writeback");
    pickRegs(a, b);
    wbCase(encR(funct7Zero, a, b, 3'b000, b, opReg), resAlu, 2'b00, b);
    pickRegs(a, b);
    wbCase(encI(12'h010, a, 3'b010, a, opLoad), resMem, 2'b10, a);
    pickRegs(a, b);
    wbCase({20'h00100, b, opJal}, resPc4, 2'b00, b);
    // Decode keeps a load while reset is held, so only reset empties the pipe
    @(posedge clk);
    instrD <= encI(12'h0, a, 3'b010, b, opLoad);
    applyReset();
    @(negedge clk);
    checkBit("regWriteW after reset", 1'b0, regWriteW);
    checkMem("memRwM after reset", 2'b00, memRwM);
    @(posedge clk);
    instrD <= nop;
    endTest();
  endtask

  task automatic testBranch();
    logic [2:0] f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    instrT ins;
    startTest("branch");
    for (int j = 0; j <= 6; j++) begin
      ins = (j < 6) ? encR(7'h00, 5'd2, 5'd1, f3s[j], 5'd0, opBranch) : {20'h0, 5'd1, opJal};
      @(posedge clk);
      instrD <= ins;
      @(posedge clk);
      instrD <= nop;
      stallE <= 1'b1;  // Hold it in E while flags sweep
      for (int fl = 0; fl < 4; fl++) begin
        @(posedge clk);
        flagsE <= 2'(fl);
        @(negedge clk);
        checkBit($sformatf("pcSrcE case %0d flags %0d", j, fl),
                 expTaken(ins[14:12], 2'(fl), j == 6), pcSrcE);
      end
      @(posedge clk);
      stallE <= 1'b0;
    end
    endTest();
  endtask

  task automatic testForwarding();
    regAddrT a, b;
    startTest("forwarding");
    pickRegs(a, b);
    fwdCase(encR(funct7Zero, b, b, 3'b000, a, opReg), 1,
            encR(funct7Zero, b, a, 3'b000, b, opReg), fwdM, fwdNone);
    pickRegs(a, b);
    fwdCase(encR(funct7Zero, b, b, 3'b000, a, opReg), 2,
            encR(funct7Zero, a, b, 3'b000, b, opReg), fwdNone, fwdW);
    fwdCase(encR(funct7Zero, b, b, 3'b000, 5'd0, opReg), 1,
            encR(funct7Zero, 5'd0, 5'd0, 3'b000, b, opReg), fwdNone, fwdNone);  // x0
    pickRegs(a, b);
    fwdCase(encR(7'h00, b, b, 3'b010, a, opStore), 1,
            encR(funct7Zero, b, a, 3'b000, b, opReg), fwdNone, fwdNone);  // Store writes no rd
    endTest();
  endtask

  task automatic testStructural();
    regAddrT a, b;
    startTest("structural");
    pickRegs(a, b);
    stallCase("load-use", encI(12'h0, b, 3'b010, a, opLoad),
              encR(funct7Zero, b, a, 3'b000, b, opReg), 1'b1);
    pickRegs(a, b);
    stallCase("mul-use", encR(funct7Mul, b, b, 3'b000, a, opReg),
              encR(funct7Zero, a, b, 3'b000, b, opReg), 1'b1);
    pickRegs(a, b);
    stallCase("store-load", encR(7'h00, b, b, 3'b010, 5'd0, opStore),
              encI(12'h0, b, 3'b010, b, opLoad), 1'b1);
    pickRegs(a, b);
    stallCase("independent", encI(12'h0, b, 3'b010, a, opLoad),
              encR(funct7Zero, b, b, 3'b000, b, opReg), 1'b0);
    endTest();
  endtask

  task automatic testStallFlush();
    regAddrT a, b;
    startTest("stall-flush");
    pickRegs(a, b);
    @(posedge clk);
    instrD <= encI(12'h005, a, 3'b010, b, opImm);    // slti
    @(posedge clk);
    instrD <= encR(funct7Zero, a, b, 3'b000, a, opReg);
    stallE <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      @(negedge clk);
      checkE(1'b0, 1'b1, 3'd2, 1'b1);                 // Still slti
    end
    @(posedge clk);
    flushE <= 1'b1;                                   // Both high
    @(posedge clk);
    flushE <= 1'b0;
    stallE <= 1'b0;
    @(negedge clk);
    checkE(1'b0, 1'b0, 3'd0, 1'b0);
    @(posedge clk);
    instrD <= encI(12'h005, a, 3'b010, b, opImm);
    @(posedge clk);
    instrD <= nop;
    flushE <= 1'b1;                                   // Flush alone
    @(posedge clk);
    flushE <= 1'b0;
    @(negedge clk);
    checkE(1'b0, 1'b0, 3'd0, 1'b0);
    endTest();
  endtask

  //////////////////////////////
  // Main sequence
  initial begin
    rstN = 1'b0;
    instrD = nop;
    flagsE = 2'b00;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    applyReset();
    testDecodeTable();
    testWriteback();
    testBranch();
    testForwarding();
    testStructural();
    testStallFlush();
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    waitCycles(5000);
    $display("timeout: the test sequence did not complete");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
src/ctrlPkg.sv
src/ctrlIf.sv
src/instrDecoder.sv
src/stagePipe.sv
src/hazardUnit.sv
src/controller.sv
sim/tbController.sv

//--- Makefile
# Verilator build and run of the controller testbench

VERILATOR ?= verilator
TOP       ?= tbController
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
